// File: fetch_core.f
+incdir+include
hw/fetch_pkg.sv
hw/fetch_unit.sv
hw/inst_mem.sv
hw/jump_resolver.sv
hw/fetch_core.sv
testbench/tb_clock_gen.sv
testbench/fetch_core_tb.sv

// File: Makefile
# Verilator build and run for the fetch front end

VERILATOR ?= verilator
TOP       ?= fetch_core_tb
FILELIST  ?= fetch_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := all tests passed

SOURCES := $(wildcard hw/*.sv testbench/*.sv include/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation did not pass, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/fetch_core_tb.sv
/* Fetch front end testbench */

`timescale 1ns/1ns

`include "rv_opcodes.svh"

module fetch_core_tb import fetch_pkg::*; ();

  localparam addr_t PC_START    = 64'h0000_0000_8000_0000;
  localparam int    MEM_AW      = 8;
  localparam int    MEM_LATENCY = 3;
  localparam int    EXEC_CYCLES = 2;
  localparam int    DEPTH       = 2 ** MEM_AW;
  localparam int    STEP_CYCLES = MEM_LATENCY + EXEC_CYCLES + 2;  // one sequential instruction

  // instructions per test
  localparam int N_RESET   = 1;
  localparam int N_LINE    = 8;
  localparam int N_JAL     = 10;
  localparam int N_JAL4    = 6;
  localparam int N_JALR    = 8;
  localparam int N_RAND    = 60;
  localparam int RUN_LIMIT = (N_RESET + N_LINE + N_JAL + N_JAL4 + N_JALR + N_RAND)
                             * STEP_CYCLES * 2 + 200;

  logic              clk;
  logic              rst;
  logic              ena;
  logic              load_we;
  logic [MEM_AW-1:0] load_addr;
  inst_t             load_data;
  addr_t             pc;
  inst_t             inst;
  logic              fetched;

  inst_t  prog [DEPTH];   // copy of what the DUT memory holds
  integer seed;
  int     err_count;
  int     test_num;
  int     fail_tests;
  int     n_expected;
  int     n_seen;
  logic   checking;
  addr_t  exp_pc;
  addr_t  nxt_pc;
  inst_t  exp_word;
  int     exp_gap;
  int     last_cycle;
  logic   have_last;
  int     cycle_count;
  int     run_cycles;

  tb_clock_gen #(.PERIOD_NS(10)) u_clk (.o_clk(clk));

  fetch_core #(
    .PC_START    (PC_START),
    .MEM_AW      (MEM_AW),
    .MEM_LATENCY (MEM_LATENCY),
    .EXEC_CYCLES (EXEC_CYCLES)
  ) uut (
    .clk         (clk),
    .rst         (rst),
    .i_ena       (ena),
    .i_load_we   (load_we),
    .i_load_addr (load_addr),
    .i_load_data (load_data),
    .o_pc        (pc),
    .o_inst      (inst),
    .o_fetched   (fetched)
  );

  ////////////////////////////////////////////////////////////////////////////
  // reference model and instruction encoding
  ////////////////////////////////////////////////////////////////////////////
  function automatic int mem_index(input addr_t a);
    return int'(a[MEM_AW+1:2]);       // word index wraps to the depth
  endfunction

  function automatic addr_t next_pc(input addr_t cur, input inst_t word);
    logic signed [20:0] j_imm;
    logic signed [11:0] i_imm;
    j_imm = {word[`RV_SIGN_BIT], word[`RV_JIMM_19_12], word[`RV_JIMM_11],
             word[`RV_JIMM_10_1], 1'b0};
    i_imm = word[`RV_IIMM_BITS];
    if (word[`RV_OPC_BITS] == `OPC_JAL) begin
      return cur + {{43{j_imm[20]}}, j_imm};
    end else if (word[`RV_OPC_BITS] == `OPC_JALR && word[`RV_RS1_BITS] == 5'd0) begin
      return {{52{i_imm[11]}}, i_imm[11:1], 1'b0};   // absolute, bit 0 cleared
    end
    return cur + 64'd4;
  endfunction

  // addi x0,x0,idx so every filler word is distinct
  function automatic inst_t filler_word(input int idx);
    return {idx[11:0], 5'd0, 3'b000, 5'd0, `OPC_OP_IMM};
  endfunction

  function automatic inst_t jal_word(input logic [4:0] rd, input int offset);
    logic [20:0] imm;
    imm = offset[20:0];
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
  endfunction

  function automatic inst_t jalr_word(input logic [4:0] rd, input logic [4:0] rs1,
                                      input int imm);
    return {imm[11:0], rs1, 3'b000, rd, `OPC_JALR};
  endfunction

  function automatic void clear_program();
    for (int i = 0; i < DEPTH; i++) begin
      prog[i] = filler_word(i);
    end
  endfunction

  // slot k is the word at PC_START + 4k
  function automatic void put_word(input int slot, input inst_t word);
    prog[mem_index(PC_START + addr_t'(slot * 4))] = word;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_pc(input addr_t got, input addr_t exp);
    if (got !== exp) begin
      err_count++;
      $display("FAILED at %0t ns: o_pc expected %h, got %h", $time, exp, got);
    end
  endtask

  task automatic check_inst(input inst_t got, input inst_t exp);
    if (got !== exp) begin
      err_count++;
      $display("FAILED at %0t ns: o_inst expected %h, got %h", $time, exp, got);
    end
  endtask

  task automatic check_gap(input int got, input int exp);
    if (got != exp) begin
      err_count++;
      $display("FAILED at %0t ns: o_fetched spacing expected %0d cycles, got %0d",
               $time, exp, got);
    end
  endtask

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    if (rst) begin
      n_seen    = 0;
      exp_pc    = PC_START;
      have_last = 1'b0;
    end else if (checking && fetched && n_seen < n_expected) begin
      exp_word = prog[mem_index(exp_pc)];
      nxt_pc   = next_pc(exp_pc, exp_word);
      check_pc(pc, exp_pc);
      check_inst(inst, exp_word);
      if (have_last) begin
        check_gap(cycle_count - last_cycle, exp_gap);
      end
      // a jump off the predicted path costs one discarded fetch
      exp_gap    = STEP_CYCLES + ((nxt_pc != exp_pc + 64'd4) ? MEM_LATENCY + 1 : 0);
      last_cycle = cycle_count;
      have_last  = 1'b1;
      exp_pc     = nxt_pc;
      n_seen++;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (!rst) begin
      run_cycles++;                     // only cycles out of reset
    end
    if (run_cycles > RUN_LIMIT) begin
      $display("timeout: test %0d saw %0d of %0d instructions", test_num, n_seen, n_expected);
      $display("tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // reset covers the program load, then 10 more cycles
  task automatic reset_and_load();
    int i;
    next_cycle();
    rst = 1'b1;
    ena = 1'b0;
    for (i = 0; i < DEPTH; i++) begin
      load_we   = 1'b1;
      load_addr = MEM_AW'(i);
      load_data = prog[i];
      next_cycle();
    end
    load_we = 1'b0;
    repeat (10) next_cycle();
    rst = 1'b0;
    ena = 1'b1;
  endtask

  task automatic run_test(input string name, input int count);
    int errs_before;
    errs_before = err_count;
    test_num++;
    n_expected = count;
    reset_and_load();
    checking = 1'b1;
    wait (n_seen >= n_expected);
    checking = 1'b0;
    if (err_count == errs_before) begin
      $display("test %0d (%s): passed, %0d instructions", test_num, name, count);
    end else begin
      fail_tests++;
      $display("test %0d (%s): failed with %0d errors", test_num, name,
               err_count - errs_before);
    end
  endtask

  initial begin
    int k;
    int r;
    int tgt;
    rst       = 1'b1;
    ena       = 1'b0;
    load_we   = 1'b0;
    load_addr = '0;
    load_data = '0;
    checking  = 1'b0;
    seed      = 32'hafbe_94e0;

    clear_program();
    run_test("reset start", N_RESET);
    run_test("straight-line code", N_LINE);

    clear_program();
    put_word(1, jal_word(5'd1, 20));    // to slot 6
    put_word(7, jal_word(5'd0, -20));   // back to slot 2
    put_word(4, jal_word(5'd0, 24));    // to slot 10
    run_test("jal forward and backward", N_JAL);

    clear_program();
    put_word(1, jal_word(5'd0, 4));
    put_word(2, jal_word(5'd1, 4));
    run_test("jal to next word", N_JAL4);

    clear_program();
    put_word(1, jalr_word(5'd0, 5'd0, 'h101));            // lands on 0x100
    prog[mem_index(64'h104)] = jalr_word(5'd1, 5'd5, 'h40); // rs1 not x0, sequential
    prog[mem_index(64'h108)] = jalr_word(5'd0, 5'd0, -255); // negative absolute
    run_test("jalr with rs1 x0", N_JALR);

    // 40 random words, every target inside the program
    clear_program();
    for (k = 0; k < 40; k++) begin
      r   = $random(seed);
      tgt = {1'b0, r[30:0]} % 40;
      if (r[2:0] == 3'd5 || r[2:0] == 3'd6) begin
        put_word(k, jal_word(r[7:3], (tgt - k) * 4));
      end else if (r[2:0] == 3'd7) begin
        put_word(k, jalr_word(r[7:3], 5'd0,
                 ((mem_index(PC_START) + tgt) % DEPTH) * 4 + int'(r[8])));
      end
    end
    run_test("random program", N_RAND);

    $display("summary: %0d tests run, %0d passed, %0d failed, %0d check errors",
             test_num, test_num - fail_tests, fail_tests, err_count);
    if (fail_tests == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: testbench/tb_clock_gen.sv
/* Testbench clock */

`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD_NS = 10
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) o_clk = ~o_clk;   // half period
    end
  end

endmodule

// File: hw/fetch_core.sv
/* Fetch front end top level */

`timescale 1ns/1ns

module fetch_core import fetch_pkg::*; #(
  parameter addr_t PC_START    = 64'h0000_0000_8000_0000,
  parameter int    MEM_AW      = 8,
  parameter int    MEM_LATENCY = 2,
  parameter int    EXEC_CYCLES = 2
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_ena,

  // program load
  input  logic              i_load_we,
  input  logic [MEM_AW-1:0] i_load_addr,
  input  inst_t             i_load_data,

  // committed stream
  output addr_t             o_pc,
  output inst_t             o_inst,
  output logic              o_fetched
);

  logic            bus_req;
  addr_t           bus_addr;
  logic            bus_ack;
  logic [XLEN-1:0] bus_rdata;
  logic            wb_done;
  logic            pc_jmp;
  addr_t           pc_jmpaddr;

  fetch_unit #(
    .PC_START     (PC_START)
  ) u_fetch (
    .clk          (clk),
    .rst          (rst),
    .i_ena        (i_ena),
    .i_bus_ack    (bus_ack),
    .i_bus_rdata  (bus_rdata),
    .o_bus_req    (bus_req),
    .o_bus_addr   (bus_addr),
    .i_wb_done    (wb_done),
    .i_pc_jmp     (pc_jmp),
    .i_pc_jmpaddr (pc_jmpaddr),
    .o_pc         (o_pc),
    .o_inst       (o_inst),
    .o_fetched    (o_fetched)
  );

  inst_mem #(
    .MEM_AW      (MEM_AW),
    .MEM_LATENCY (MEM_LATENCY)
  ) u_mem (
    .clk         (clk),
    .rst         (rst),
    .i_bus_req   (bus_req),
    .i_bus_addr  (bus_addr),
    .o_bus_ack   (bus_ack),
    .o_bus_rdata (bus_rdata),
    .i_load_we   (i_load_we),
    .i_load_addr (i_load_addr),
    .i_load_data (i_load_data)
  );

  // stands in for decode through writeback
  jump_resolver #(
    .EXEC_CYCLES  (EXEC_CYCLES)
  ) u_resolver (
    .clk          (clk),
    .rst          (rst),
    .i_fetched    (o_fetched),
    .i_pc         (o_pc),
    .i_inst       (o_inst),
    .o_wb_done    (wb_done),
    .o_pc_jmp     (pc_jmp),
    .o_pc_jmpaddr (pc_jmpaddr)
  );

endmodule

// File: hw/jump_resolver.sv
/* Jump resolver and writeback timing */

`timescale 1ns/1ns

`include "rv_opcodes.svh"

module jump_resolver import fetch_pkg::*; #(
  parameter int EXEC_CYCLES = 2
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  i_fetched,
  input  addr_t i_pc,
  input  inst_t i_inst,
  output logic  o_wb_done,
  output logic  o_pc_jmp,
  output addr_t o_pc_jmpaddr
);

  localparam int CNT_W = $clog2(EXEC_CYCLES) + 1;

  res_state_t       state;
  logic [CNT_W-1:0] exec_cnt;
  addr_t            pc_q;
  inst_t            inst_q;
  logic             is_jal;
  logic             is_jalr_abs;
  addr_t            jal_imm;
  addr_t            jalr_imm;

  always_ff @(posedge clk) begin
    if (i_fetched) begin
      pc_q   <= i_pc;
      inst_q <= i_inst;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////////////////////
  assign is_jal      = (inst_q[`RV_OPC_BITS] == `OPC_JAL);
  assign is_jalr_abs = (inst_q[`RV_OPC_BITS] == `OPC_JALR) &&
                       (inst_q[`RV_RS1_BITS] == 5'd0);      // base is x0

  assign jal_imm  = {{44{inst_q[`RV_SIGN_BIT]}}, inst_q[`RV_JIMM_19_12],
                     inst_q[`RV_JIMM_11], inst_q[`RV_JIMM_10_1], 1'b0};
  assign jalr_imm = {{52{inst_q[`RV_SIGN_BIT]}}, inst_q[`RV_IIMM_BITS]};

  assign o_pc_jmpaddr = is_jal ? (pc_q + jal_imm) : {jalr_imm[XLEN-1:1], 1'b0};

  ////////////////////////////////////////////////////////////////////////////
  // execute timing
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= RES_IDLE;
      exec_cnt <= '0;
    end else begin
      case (state)
        RES_IDLE: begin
          if (i_fetched) begin
            exec_cnt <= CNT_W'(1);
            state    <= (EXEC_CYCLES == 1) ? RES_WB : RES_EXEC;
          end
        end
        RES_EXEC: begin
          if (exec_cnt == CNT_W'(EXEC_CYCLES - 1)) begin
            state <= RES_WB;
          end else begin
            exec_cnt <= exec_cnt + 1'b1;
          end
        end
        RES_WB:  state <= RES_IDLE;
        default: state <= RES_IDLE;
      endcase
    end
  end

  assign o_wb_done = (state == RES_WB);
  assign o_pc_jmp  = o_wb_done & (is_jal | is_jalr_abs);

  // writeback comes EXEC_CYCLES after the fetch
  a_wb_timing: assert property (@(posedge clk) disable iff (rst)
    o_wb_done |-> $past(i_fetched, EXEC_CYCLES));

  // fetch never outruns writeback
  a_fetch_idle: assert property (@(posedge clk) disable iff (rst)
    i_fetched |-> state == RES_IDLE);

endmodule

// File: hw/inst_mem.sv
/* Instruction memory with wait states */

`timescale 1ns/1ns

module inst_mem import fetch_pkg::*; #(
  parameter int MEM_AW      = 8,
  parameter int MEM_LATENCY = 2
) (
  input  logic              clk,
  input  logic              rst,

  // fetch bus
  input  logic              i_bus_req,
  input  addr_t             i_bus_addr,
  output logic              o_bus_ack,
  output logic [XLEN-1:0]   o_bus_rdata,

  // load port
  input  logic              i_load_we,
  input  logic [MEM_AW-1:0] i_load_addr,
  input  inst_t             i_load_data
);

  localparam int DEPTH = 2 ** MEM_AW;
  localparam int CNT_W = $clog2(MEM_LATENCY) + 1;

  inst_t             mem [DEPTH];
  logic [CNT_W-1:0]  wait_cnt;
  logic              last_wait;
  logic [MEM_AW-1:0] word_idx;
  logic [MEM_AW-1:0] lo_idx;
  logic [MEM_AW-1:0] hi_idx;

  // word index wraps to the depth
  assign word_idx  = i_bus_addr[MEM_AW+1:2];
  assign lo_idx    = word_idx & ~MEM_AW'(1);
  assign hi_idx    = word_idx | MEM_AW'(1);
  assign last_wait = (wait_cnt == CNT_W'(MEM_LATENCY - 1));

  always_ff @(posedge clk) begin
    if (i_load_we) begin
      mem[i_load_addr] <= i_load_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // wait states
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      wait_cnt  <= '0;
      o_bus_ack <= 1'b0;
    end else begin
      o_bus_ack <= 1'b0;
      if (!i_bus_req) begin
        wait_cnt <= '0;
      end else if (!o_bus_ack) begin       // no back-to-back acks
        if (last_wait) begin
          wait_cnt  <= '0;
          o_bus_ack <= 1'b1;
        end else begin
          wait_cnt  <= wait_cnt + 1'b1;
        end
      end
    end
  end

  // aligned doubleword, both halves
  always_ff @(posedge clk) begin
    if (i_bus_req && !o_bus_ack && last_wait) begin
      o_bus_rdata <= {mem[hi_idx], mem[lo_idx]};
    end
  end

  a_ack_has_req: assert property (@(posedge clk) disable iff (rst)
    o_bus_ack |-> i_bus_req);

endmodule

// File: hw/fetch_unit.sv
/* Instruction fetch unit */

`timescale 1ns/1ns

module fetch_unit import fetch_pkg::*; #(
  parameter addr_t PC_START = 64'h0000_0000_8000_0000
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            i_ena,

  // instruction bus
  input  logic            i_bus_ack,
  input  logic [XLEN-1:0] i_bus_rdata,
  output logic            o_bus_req,
  output addr_t           o_bus_addr,

  // writeback side
  input  logic            i_wb_done,
  input  logic            i_pc_jmp,
  input  addr_t           i_pc_jmpaddr,
  output addr_t           o_pc,
  output inst_t           o_inst,
  output logic            o_fetched
);

  logic  handshake;
  logic  redirect;
  logic  refetch;         // word under way is thrown away
  logic  wb_pend;         // writeback seen while disabled
  addr_t saved_jmpaddr;
  addr_t pc_pred;         // predicted next PC
  inst_t fetch_word;

  assign handshake  = o_bus_req & i_bus_ack;
  assign redirect   = i_pc_jmp & (i_pc_jmpaddr != pc_pred);
  assign fetch_word = o_bus_addr[2] ? i_bus_rdata[63:32] : i_bus_rdata[31:0];

  ////////////////////////////////////////////////////////////////////////////
  // request control
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      o_bus_req <= 1'b1;
      wb_pend   <= 1'b0;
    end else begin
      if (handshake) begin
        if (!refetch) begin
          o_bus_req <= 1'b0;        // keep going when refetching
        end
      end else if (i_wb_done || wb_pend) begin
        if (i_ena) begin
          o_bus_req <= 1'b1;
          wb_pend   <= 1'b0;
        end else begin
          wb_pend   <= 1'b1;
        end
      end
    end
  end

  // jump redirect
  always_ff @(posedge clk) begin
    if (rst) begin
      refetch <= 1'b0;
    end else if (redirect) begin
      refetch <= 1'b1;
    end else if (handshake) begin
      refetch <= 1'b0;              // discarded word consumed
    end
  end

  always_ff @(posedge clk) begin
    if (redirect) begin
      saved_jmpaddr <= i_pc_jmpaddr;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // fetch
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      o_bus_addr <= PC_START;
      o_pc       <= '0;
      pc_pred    <= PC_START;
      o_fetched  <= 1'b0;
    end else begin
      o_fetched <= 1'b0;
      if (handshake) begin
        if (refetch) begin
          o_bus_addr <= saved_jmpaddr;      // restart at the target
        end else begin
          o_bus_addr <= o_bus_addr + 64'd4;
          o_pc       <= o_bus_addr;
          pc_pred    <= o_bus_addr + 64'd4;
          o_fetched  <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (handshake && !refetch) begin
      o_inst <= fetch_word;
    end
  end

  // address must hold until the memory answers
  a_addr_stable: assert property (@(posedge clk) disable iff (rst)
    o_bus_req && !i_bus_ack |=> $stable(o_bus_addr));

  // only one instruction in flight
  a_wb_idle: assert property (@(posedge clk) disable iff (rst)
    i_wb_done |-> !o_bus_req);

endmodule

// File: hw/fetch_pkg.sv
/* Fetch front end types */

package fetch_pkg;

  localparam int XLEN = 64;     // address and bus data width
  localparam int ILEN = 32;     // instruction word width

  // byte address or PC
  typedef logic [XLEN-1:0] addr_t;

  // one instruction word
  typedef logic [ILEN-1:0] inst_t;

  ////////////////////////////////////////////////////////////////////////////
  // jump resolver FSM
  //   RES_IDLE  waiting for a fetched instruction
  //   RES_EXEC  counting execute cycles
  //   RES_WB    writeback pulse
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    RES_IDLE = 2'd0,
    RES_EXEC = 2'd1,
    RES_WB   = 2'd2
  } res_state_t;

endpackage

// File: include/rv_opcodes.svh
/* RV opcodes and instruction field positions */

`ifndef RV_OPCODES_SVH
`define RV_OPCODES_SVH

// major opcodes
`define OPC_JAL       7'b1101111
`define OPC_JALR      7'b1100111
`define OPC_OP_IMM    7'b0010011

// common fields
`define RV_OPC_BITS   6:0
`define RV_RD_BITS    11:7
`define RV_RS1_BITS   19:15

// immediates
`define RV_SIGN_BIT   31
`define RV_IIMM_BITS  31:20
`define RV_JIMM_19_12 19:12     // imm[19:12]
`define RV_JIMM_11    20        // imm[11]
`define RV_JIMM_10_1  30:21     // imm[10:1]

`endif
